//--- design/sha_accel_pkg.sv
package sha_accel_pkg;

	// --------------------
	// core data-memory bus encodings

	// bus command
	typedef enum logic {
		MEM_CMD_RD = 1'b0,
		MEM_CMD_WR = 1'b1
	} mem_cmd_e;

	// access width
	typedef enum logic [1:0] {
		MEM_WIDTH_BYTE  = 2'b00,
		MEM_WIDTH_HWORD = 2'b01,
		MEM_WIDTH_WORD  = 2'b10
	} mem_width_e;

	// bus response
	typedef enum logic {
		MEM_RESP_NOTRDY = 1'b0,
		MEM_RESP_RDY_OK = 1'b1
	} mem_resp_e;

	// --------------------
	// data words

	typedef logic [31:0] word_t;

	// word index from address bits 8 to 2
	typedef logic [6:0] word_idx_t;

	// decoded register write with replicated data
	typedef struct packed {
		logic      en;
		word_idx_t idx;
		word_t     data;
	} bus_wr_t;

	// one message word seen whole or as bytes
	// byte 0 is the least significant
	typedef union packed {
		word_t           word;
		logic [3:0][7:0] bytes;
	} msg_word_u;

	// --------------------
	// register map in word indices

	localparam word_idx_t IDX_CTRL       = 7'd0;
	localparam word_idx_t IDX_STEP       = 7'd1;
	// 2 to 12 unused and read zero
	localparam word_idx_t IDX_MSG_BASE   = 7'd13;
	localparam word_idx_t IDX_SCHED_BASE = 7'd29;

	localparam int NUM_MSG_WORDS   = 16;
	localparam int NUM_SCHED_WORDS = 64;

	// --------------------
	// sigma rotate and shift amounts

	// small sigma0
	localparam logic [4:0] SIG0_ROT1 = 5'd7;
	localparam logic [4:0] SIG0_ROT2 = 5'd18;
	localparam logic [4:0] SIG0_SHR  = 5'd3;
	// small sigma1
	localparam logic [4:0] SIG1_ROT1 = 5'd17;
	localparam logic [4:0] SIG1_ROT2 = 5'd19;
	localparam logic [4:0] SIG1_SHR  = 5'd10;

endpackage : sha_accel_pkg

//--- design/dmem_port.sv
`timescale 1ns/1ps

module dmem_port (
	input  logic                      clk,
	input  logic                      rst_n,
	// core side
	input  logic                      req,
	input  sha_accel_pkg::mem_cmd_e   cmd,
	input  sha_accel_pkg::mem_width_e width,
	input  logic [31:0]               addr,
	input  sha_accel_pkg::word_t      wdata,
	output logic                      req_ack,
	output sha_accel_pkg::word_t      rdata,
	output sha_accel_pkg::mem_resp_e  resp,
	// register side
	input  sha_accel_pkg::word_t      status,
	input  logic [15:0]               step_count,
	input  sha_accel_pkg::word_t      msg_rword,
	input  sha_accel_pkg::word_t      sched_rword,
	output sha_accel_pkg::bus_wr_t    wr,
	output sha_accel_pkg::word_idx_t  rd_idx
);

	logic                 rd_en;
	sha_accel_pkg::word_t wr_data;
	sha_accel_pkg::word_t rd_word;
	sha_accel_pkg::word_t rd_word_q;
	logic [1:0]           rd_shift_q;

	// --------------------
	// handshake

	// always ready with no back-pressure
	assign req_ack = 1'b1;

	// resp follows req by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp <= sha_accel_pkg::MEM_RESP_NOTRDY;
		end else if (req) begin
			resp <= sha_accel_pkg::MEM_RESP_RDY_OK;
		end else begin
			resp <= sha_accel_pkg::MEM_RESP_NOTRDY;
		end
	end

	// --------------------
	// write side

	// narrow writes replicate the low lane over the word
	always_comb begin
		case (width)
			sha_accel_pkg::MEM_WIDTH_BYTE:  wr_data = {4{wdata[7:0]}};
			sha_accel_pkg::MEM_WIDTH_HWORD: wr_data = {2{wdata[15:0]}};
			default:                        wr_data = wdata;
		endcase
	end

	assign wr.en   = req && (cmd == sha_accel_pkg::MEM_CMD_WR);
	assign wr.idx  = addr[8:2];
	assign wr.data = wr_data;

	// --------------------
	// read side

	assign rd_en  = req && (cmd == sha_accel_pkg::MEM_CMD_RD);
	assign rd_idx = addr[8:2];

	// units return zero outside their range so OR is enough
	always_comb begin
		case (rd_idx)
			sha_accel_pkg::IDX_CTRL: rd_word = status;
			sha_accel_pkg::IDX_STEP: rd_word = {16'b0, step_count};
			default:                 rd_word = msg_rword | sched_rword;
		endcase
	end

	// word and byte offset captured at the request edge
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_word_q  <= rd_word;
			rd_shift_q <= addr[1:0];
		end
	end

	// shift right by 8 x offset
	assign rdata = rd_word_q >> {rd_shift_q, 3'b000};

endmodule : dmem_port

//--- design/sched_ctrl.sv
`timescale 1ns/1ps

module sched_ctrl #(
	parameter int EXPAND_PER_STEP = 2
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  sha_accel_pkg::bus_wr_t wr,
	output sha_accel_pkg::word_t   status,
	output logic [15:0]            step_count,
	output logic                   step_en,
	output logic [5:0]             step
);

	// step 0 loads and later steps expand 48 words in groups
	localparam int NUM_EXP_WORDS =
		sha_accel_pkg::NUM_SCHED_WORDS - sha_accel_pkg::NUM_MSG_WORDS;
	localparam logic [15:0] LAST_STEP = 16'(NUM_EXP_WORDS / EXPAND_PER_STEP);

	logic go;
	logic busy;
	logic done;

	// go is any write to the control word
	assign go = wr.en && (wr.idx == sha_accel_pkg::IDX_CTRL);

	// a bus write cycle stalls the step
	assign step_en = busy && !wr.en;
	assign step    = step_count[5:0];

	// done on bit 31 and busy on bit 0
	assign status = {done, 30'b0, busy};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step_count <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
		end else if (go) begin
			// restart even mid run
			step_count <= '0;
			busy       <= 1'b1;
			done       <= 1'b0;
		end else if (step_en) begin
			step_count <= step_count + 16'd1;
			// last step issued this cycle
			if (step_count == LAST_STEP) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule : sched_ctrl

//--- design/msg_block_regs.sv
`timescale 1ns/1ps

module msg_block_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  sha_accel_pkg::bus_wr_t   wr,
	input  sha_accel_pkg::word_idx_t rd_idx,
	output sha_accel_pkg::word_t     block [sha_accel_pkg::NUM_MSG_WORDS],
	output sha_accel_pkg::word_t     rword
);

	sha_accel_pkg::word_idx_t wr_off;
	sha_accel_pkg::word_idx_t rd_off;
	logic                     wr_hit;
	logic                     rd_hit;

	// offsets below the base wrap high
	// so one compare checks both ends
	assign wr_off = wr.idx - sha_accel_pkg::IDX_MSG_BASE;
	assign rd_off = rd_idx - sha_accel_pkg::IDX_MSG_BASE;
	assign wr_hit = wr.en && (wr_off < 7'(sha_accel_pkg::NUM_MSG_WORDS));
	assign rd_hit = rd_off < 7'(sha_accel_pkg::NUM_MSG_WORDS);

	// block words cleared by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sha_accel_pkg::NUM_MSG_WORDS; i++) begin
				block[i] <= '0;
			end
		end else if (wr_hit) begin
			block[wr_off[3:0]] <= wr.data;
		end
	end

	// zero when not ours
	assign rword = rd_hit ? block[rd_off[3:0]] : '0;

endmodule : msg_block_regs

//--- design/sched_expand.sv
`timescale 1ns/1ps

module sched_expand #(
	parameter int EXPAND_PER_STEP = 2
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  sha_accel_pkg::bus_wr_t   wr,
	input  sha_accel_pkg::word_idx_t rd_idx,
	input  sha_accel_pkg::word_t     block [sha_accel_pkg::NUM_MSG_WORDS],
	input  logic                     step_en,
	input  logic [5:0]               step,
	output sha_accel_pkg::word_t     rword
);

	sha_accel_pkg::word_t     w      [sha_accel_pkg::NUM_SCHED_WORDS];
	sha_accel_pkg::word_t     load_w [sha_accel_pkg::NUM_MSG_WORDS];
	sha_accel_pkg::word_t     new_w  [EXPAND_PER_STEP];
	logic [5:0]               exp_base;
	sha_accel_pkg::word_idx_t wr_off;
	sha_accel_pkg::word_idx_t rd_off;
	logic                     wr_hit;
	logic                     rd_hit;

	// --------------------
	// sigma functions

	function automatic sha_accel_pkg::word_t rotr(input sha_accel_pkg::word_t x,
			input logic [4:0] n);
		return (x >> n) | (x << (6'd32 - {1'b0, n}));
	endfunction

	function automatic sha_accel_pkg::word_t sig0(input sha_accel_pkg::word_t x);
		return rotr(x, sha_accel_pkg::SIG0_ROT1) ^ rotr(x, sha_accel_pkg::SIG0_ROT2)
			^ (x >> sha_accel_pkg::SIG0_SHR);
	endfunction

	function automatic sha_accel_pkg::word_t sig1(input sha_accel_pkg::word_t x);
		return rotr(x, sha_accel_pkg::SIG1_ROT1) ^ rotr(x, sha_accel_pkg::SIG1_ROT2)
			^ (x >> sha_accel_pkg::SIG1_SHR);
	endfunction

	// --------------------
	// step 0 big-endian load

	always_comb begin
		sha_accel_pkg::msg_word_u swap_in;
		sha_accel_pkg::msg_word_u swap_out;
		for (int i = 0; i < sha_accel_pkg::NUM_MSG_WORDS; i++) begin
			swap_in.word = block[i];
			// reverse byte order
			for (int b = 0; b < 4; b++) begin
				swap_out.bytes[b] = swap_in.bytes[3 - b];
			end
			load_w[i] = swap_out.word;
		end
	end

	// --------------------
	// expansion in steps 1 and on

	// first word produced by this step
	assign exp_base = 6'(sha_accel_pkg::NUM_MSG_WORDS + (int'(step) - 1) * EXPAND_PER_STEP);

	for (genvar j = 0; j < EXPAND_PER_STEP; j++) begin : g_exp
		logic [5:0]           idx;
		sha_accel_pkg::word_t prev2;
		sha_accel_pkg::word_t new_word;
		assign idx = exp_base + 6'(j);
		// i-2 comes from this same step once j reaches 2
		if (j >= 2) begin : g_chain
			assign prev2 = g_exp[j - 2].new_word;
		end else begin : g_reg
			assign prev2 = w[idx - 6'd2];
		end
		assign new_word = sig1(prev2) + w[idx - 6'd7]
			+ sig0(w[idx - 6'd15]) + w[idx - 6'd16];
		assign new_w[j] = new_word;
	end

	// host writes to indices 29 to 92 land here too
	assign wr_off = wr.idx - sha_accel_pkg::IDX_SCHED_BASE;
	assign rd_off = rd_idx - sha_accel_pkg::IDX_SCHED_BASE;
	assign wr_hit = wr.en && (wr_off < 7'(sha_accel_pkg::NUM_SCHED_WORDS));
	assign rd_hit = rd_off < 7'(sha_accel_pkg::NUM_SCHED_WORDS);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sha_accel_pkg::NUM_SCHED_WORDS; i++) begin
				w[i] <= '0;
			end
		end else if (wr_hit) begin
			w[wr_off[5:0]] <= wr.data;
		end else if (step_en) begin
			if (step == 6'd0) begin
				for (int i = 0; i < sha_accel_pkg::NUM_MSG_WORDS; i++) begin
					w[i] <= load_w[i];
				end
			end else begin
				// other words hold
				for (int j = 0; j < EXPAND_PER_STEP; j++) begin
					w[exp_base + 6'(j)] <= new_w[j];
				end
			end
		end
	end

	assign rword = rd_hit ? w[rd_off[5:0]] : '0;

endmodule : sched_expand

//--- design/sha_accel_top.sv
`timescale 1ns/1ps

module sha_accel_top #(
	parameter int EXPAND_PER_STEP = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	// core data-memory port
	output logic                      dmem_req_ack,
	input  logic                      dmem_req,
	input  sha_accel_pkg::mem_cmd_e   dmem_cmd,
	input  sha_accel_pkg::mem_width_e dmem_width,
	input  logic [31:0]               dmem_addr,
	input  sha_accel_pkg::word_t      dmem_wdata,
	output sha_accel_pkg::word_t      dmem_rdata,
	output sha_accel_pkg::mem_resp_e  dmem_resp
);

	// decoded bus
	sha_accel_pkg::bus_wr_t   wr;
	sha_accel_pkg::word_idx_t rd_idx;
	// readback
	sha_accel_pkg::word_t     status;
	logic [15:0]              step_count;
	sha_accel_pkg::word_t     msg_rword;
	sha_accel_pkg::word_t     sched_rword;
	// step issue
	logic                     step_en;
	logic [5:0]               step;
	sha_accel_pkg::word_t     block [sha_accel_pkg::NUM_MSG_WORDS];

	dmem_port u_dmem_port (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (dmem_req),
		.cmd         (dmem_cmd),
		.width       (dmem_width),
		.addr        (dmem_addr),
		.wdata       (dmem_wdata),
		.req_ack     (dmem_req_ack),
		.rdata       (dmem_rdata),
		.resp        (dmem_resp),
		.status      (status),
		.step_count  (step_count),
		.msg_rword   (msg_rword),
		.sched_rword (sched_rword),
		.wr          (wr),
		.rd_idx      (rd_idx)
	);

	sched_ctrl #(
		.EXPAND_PER_STEP (EXPAND_PER_STEP)
	) u_sched_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr         (wr),
		.status     (status),
		.step_count (step_count),
		.step_en    (step_en),
		.step       (step)
	);

	msg_block_regs u_msg_block_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (wr),
		.rd_idx (rd_idx),
		.block  (block),
		.rword  (msg_rword)
	);

	sched_expand #(
		.EXPAND_PER_STEP (EXPAND_PER_STEP)
	) u_sched_expand (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (wr),
		.rd_idx  (rd_idx),
		.block   (block),
		.step_en (step_en),
		.step    (step),
		.rword   (sched_rword)
	);

endmodule : sha_accel_top

//--- test/sha_accel_checker.sv
`timescale 1ns/1ps

module sha_accel_checker #(
	parameter int EXPAND_PER_STEP = 2
) (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      dmem_req,
	input sha_accel_pkg::mem_cmd_e   dmem_cmd,
	input sha_accel_pkg::mem_width_e dmem_width,
	input logic [31:0]               dmem_addr,
	input sha_accel_pkg::word_t      dmem_wdata,
	input logic                      dmem_req_ack,
	input sha_accel_pkg::word_t      dmem_rdata,
	input sha_accel_pkg::mem_resp_e  dmem_resp
);

	localparam int LAST_STEP = 48 / EXPAND_PER_STEP;

	// reference model of the register map
	sha_accel_pkg::word_t msg_m   [16];
	sha_accel_pkg::word_t sched_m [64];
	int                   count_m;
	bit                   busy_m;
	bit                   done_m;

	// read in flight
	bit                   req_q;
	bit                   pending;
	sha_accel_pkg::word_t exp_word;
	int                   exp_idx;
	int                   exp_off;

	int                   error_count;
	int                   check_count;

	// --------------------
	// sha-256 small sigmas

	function automatic sha_accel_pkg::word_t ror32(input sha_accel_pkg::word_t x, input int n);
		logic [63:0] d;
		d = {x, x} >> n;
		return d[31:0];
	endfunction

	function automatic sha_accel_pkg::word_t small_sigma0(input sha_accel_pkg::word_t x);
		return ror32(x, sha_accel_pkg::SIG0_ROT1) ^ ror32(x, sha_accel_pkg::SIG0_ROT2)
			^ (x >> sha_accel_pkg::SIG0_SHR);
	endfunction

	function automatic sha_accel_pkg::word_t small_sigma1(input sha_accel_pkg::word_t x);
		return ror32(x, sha_accel_pkg::SIG1_ROT1) ^ ror32(x, sha_accel_pkg::SIG1_ROT2)
			^ (x >> sha_accel_pkg::SIG1_SHR);
	endfunction

	// value of a word index as the map defines it
	function automatic sha_accel_pkg::word_t model_word(input int idx);
		if (idx == 0) begin
			return {done_m, 30'b0, busy_m};
		end else if (idx == 1) begin
			return sha_accel_pkg::word_t'(count_m);
		end else if (idx >= 13 && idx < 29) begin
			return msg_m[idx - 13];
		end else if (idx >= 29 && idx < 93) begin
			return sched_m[idx - 29];
		end
		// unused indices
		return '0;
	endfunction

	task automatic apply_write(input int idx, input sha_accel_pkg::word_t d);
		if (idx == 0) begin
			// go restarts any run
			count_m = 0;
			busy_m  = 1'b1;
			done_m  = 1'b0;
		end else if (idx >= 13 && idx < 29) begin
			msg_m[idx - 13] = d;
		end else if (idx >= 29 && idx < 93) begin
			sched_m[idx - 29] = d;
		end
	endtask

	task automatic run_step();
		sha_accel_pkg::msg_word_u u;
		int                       i;
		if (count_m == 0) begin
			// big-endian load
			for (int k = 0; k < 16; k++) begin
				u.word     = msg_m[k];
				sched_m[k] = {u.bytes[0], u.bytes[1], u.bytes[2], u.bytes[3]};
			end
		end else begin
			for (int j = 0; j < EXPAND_PER_STEP; j++) begin
				i = 16 + (count_m - 1) * EXPAND_PER_STEP + j;
				sched_m[i] = small_sigma1(sched_m[i - 2]) + sched_m[i - 7]
					+ small_sigma0(sched_m[i - 15]) + sched_m[i - 16];
			end
		end
		if (count_m == LAST_STEP) begin
			busy_m = 1'b0;
			done_m = 1'b1;
		end
		count_m++;
	endtask

	// compare a model schedule word with a file value
	task automatic check_model_word(input int idx, input sha_accel_pkg::word_t file_word);
		check_count++;
		if (sched_m[idx] !== file_word) begin
			error_count++;
			$display("CHECK FAILED at %0t: schedule word %0d is %h, pattern file has %h",
				$time, idx, sched_m[idx], file_word);
		end
	endtask

	// --------------------
	// bus sampling at the request edge

	always @(posedge clk or negedge rst_n) begin
		sha_accel_pkg::word_t d;
		int                   idx;
		int                   lane_bytes;
		if (!rst_n) begin
			for (int k = 0; k < 16; k++) begin
				msg_m[k] = '0;
			end
			for (int k = 0; k < 64; k++) begin
				sched_m[k] = '0;
			end
			count_m = 0;
			busy_m  = 1'b0;
			done_m  = 1'b0;
			req_q   = 1'b0;
			pending = 1'b0;
		end else begin
			idx     = int'(dmem_addr[8:2]);
			req_q   = dmem_req;
			pending = dmem_req && (dmem_cmd == sha_accel_pkg::MEM_CMD_RD);
			if (pending) begin
				exp_idx  = idx;
				exp_off  = int'(dmem_addr[1:0]);
				exp_word = model_word(idx) >> (8 * exp_off);
			end
			if (dmem_req && (dmem_cmd == sha_accel_pkg::MEM_CMD_WR)) begin
				// every lane takes the matching byte of the low lane
				if (dmem_width == sha_accel_pkg::MEM_WIDTH_BYTE) begin
					lane_bytes = 1;
				end else if (dmem_width == sha_accel_pkg::MEM_WIDTH_HWORD) begin
					lane_bytes = 2;
				end else begin
					lane_bytes = 4;
				end
				for (int b = 0; b < 4; b++) begin
					d[8 * b +: 8] = dmem_wdata[8 * (b % lane_bytes) +: 8];
				end
				apply_write(idx, d);
			end else if (busy_m) begin
				// a write cycle stalls and any other runs a step
				run_step();
			end
		end
	end

	// --------------------
	// response checks at mid cycle

	always @(negedge clk) begin
		if (rst_n) begin
			if (dmem_req_ack !== 1'b1) begin
				error_count++;
				$display("CHECK FAILED at %0t: req_ack is %b", $time, dmem_req_ack);
			end
			if (req_q && dmem_resp !== sha_accel_pkg::MEM_RESP_RDY_OK) begin
				error_count++;
				$display("CHECK FAILED at %0t: no ready response after a request", $time);
			end
			if (!req_q && dmem_resp !== sha_accel_pkg::MEM_RESP_NOTRDY) begin
				error_count++;
				$display("CHECK FAILED at %0t: response without a request", $time);
			end
			if (pending) begin
				check_count++;
				if (dmem_rdata !== exp_word) begin
					error_count++;
					$display("CHECK FAILED at %0t: read idx %0d offset %0d got %h expected %h",
						$time, exp_idx, exp_off, dmem_rdata, exp_word);
				end
			end
		end
	end

endmodule : sha_accel_checker

//--- test/tb_sha_accel.sv
`timescale 1ns/1ps

module tb_sha_accel;

	localparam int EXPAND_PER_STEP = 2;
	localparam int VEC_WORDS       = 18;
	localparam int MAX_POLL        = 40;
	localparam int RESET_CYCLES    = 10;
	localparam int RUN_CYCLES      = 25;
	localparam int NUM_GO          = 3;

	// --------------------
	// run length in bus operations per test
	localparam int OPS_RESET  = 7;
	localparam int OPS_RDBACK = 20;
	localparam int OPS_NARROW = 4;
	localparam int OPS_RUN    = 16 + 1 + MAX_POLL + 66;
	localparam int OPS_STALL  = 1 + 2 * MAX_POLL + 66;
	localparam int OPS_RERUN  = 16 + 1 + MAX_POLL + 66;
	localparam int OPS_TOTAL  = OPS_RESET + OPS_RDBACK + OPS_NARROW + OPS_RUN + OPS_STALL
		+ OPS_RERUN;
	localparam int TIMEOUT_CYCLES = 4 * (OPS_TOTAL + NUM_GO * RUN_CYCLES) + RESET_CYCLES;

	logic                      clk;
	logic                      rst_n;
	logic                      dmem_req;
	sha_accel_pkg::mem_cmd_e   dmem_cmd;
	sha_accel_pkg::mem_width_e dmem_width;
	logic [31:0]               dmem_addr;
	sha_accel_pkg::word_t      dmem_wdata;
	logic                      dmem_req_ack;
	sha_accel_pkg::word_t      dmem_rdata;
	sha_accel_pkg::mem_resp_e  dmem_resp;

	sha_accel_pkg::word_t      patterns [2 * VEC_WORDS];
	int                        seed;
	int                        cycle_count;
	int                        other_errors;

	sha_accel_top #(
		.EXPAND_PER_STEP (EXPAND_PER_STEP)
	) u_sha_accel_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.dmem_req_ack (dmem_req_ack),
		.dmem_req     (dmem_req),
		.dmem_cmd     (dmem_cmd),
		.dmem_width   (dmem_width),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_rdata   (dmem_rdata),
		.dmem_resp    (dmem_resp)
	);

	sha_accel_checker #(
		.EXPAND_PER_STEP (EXPAND_PER_STEP)
	) u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.dmem_req     (dmem_req),
		.dmem_cmd     (dmem_cmd),
		.dmem_width   (dmem_width),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_req_ack (dmem_req_ack),
		.dmem_rdata   (dmem_rdata),
		.dmem_resp    (dmem_resp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: test sequence still running after %0d cycles", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------
	// bus driver called on a falling edge

	task automatic bus_write(input int idx, input sha_accel_pkg::mem_width_e width,
			input sha_accel_pkg::word_t data);
		dmem_req   = 1'b1;
		dmem_cmd   = sha_accel_pkg::MEM_CMD_WR;
		dmem_width = width;
		dmem_addr  = 32'(idx) << 2;
		dmem_wdata = data;
		@(negedge clk);
		dmem_req   = 1'b0;
	endtask

	task automatic bus_read(input int idx, input int off, output sha_accel_pkg::word_t data);
		dmem_req   = 1'b1;
		dmem_cmd   = sha_accel_pkg::MEM_CMD_RD;
		dmem_width = sha_accel_pkg::MEM_WIDTH_WORD;
		dmem_addr  = (32'(idx) << 2) | 32'(off & 3);
		@(negedge clk);
		dmem_req   = 1'b0;
		// response cycle
		data       = dmem_rdata;
	endtask

	// zero to two idle cycles
	task automatic idle_gap();
		int n;
		n = int'($unsigned($random(seed)) % 3);
		repeat (n) @(negedge clk);
	endtask

	// poll the status word with optional stall writes to unused index 5
	task automatic wait_done(input bit stall);
		sha_accel_pkg::word_t st;
		int                   polls;
		st    = '0;
		polls = 0;
		while (!st[31] && polls < MAX_POLL) begin
			if (stall && ($random(seed) & 1)) begin
				bus_write(5, sha_accel_pkg::MEM_WIDTH_WORD,
					sha_accel_pkg::word_t'($random(seed)));
			end
			bus_read(0, 0, st);
			idle_gap();
			polls++;
		end
		if (!st[31]) begin
			other_errors++;
			$display("done flag still clear after %0d status polls", polls);
		end
	endtask

	task automatic load_vector(input int v);
		for (int i = 0; i < 16; i++) begin
			bus_write(13 + i, sha_accel_pkg::MEM_WIDTH_WORD, patterns[v * VEC_WORDS + i]);
		end
	endtask

	// every read is compared by the checker
	task automatic read_schedule(input int v);
		sha_accel_pkg::word_t d;
		for (int i = 0; i < 64; i++) begin
			bus_read(29 + i, 0, d);
		end
		bus_read(1, 0, d);
		bus_read(0, 0, d);
		u_checker.check_model_word(16, patterns[v * VEC_WORDS + 16]);
		u_checker.check_model_word(63, patterns[v * VEC_WORDS + 17]);
	endtask

	initial begin
		sha_accel_pkg::word_t d;
		rst_n        = 1'b0;
		dmem_req     = 1'b0;
		dmem_cmd     = sha_accel_pkg::MEM_CMD_RD;
		dmem_width   = sha_accel_pkg::MEM_WIDTH_WORD;
		dmem_addr    = '0;
		dmem_wdata   = '0;
		seed         = 32'hc4e8bc46;
		cycle_count  = 0;
		other_errors = 0;
		$readmemh("test/sha_accel_patterns.hex", patterns);

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// ----- reset values
		bus_read(0, 0, d);
		bus_read(1, 0, d);
		bus_read(13, 0, d);
		bus_read(28, 0, d);
		bus_read(29, 0, d);
		bus_read(92, 0, d);
		bus_read(5, 0, d);

		// ----- word writes, offset reads
		for (int i = 0; i < 4; i++) begin
			bus_write(13 + i, sha_accel_pkg::MEM_WIDTH_WORD,
				sha_accel_pkg::word_t'($random(seed)));
			idle_gap();
			for (int off = 0; off < 4; off++) begin
				bus_read(13 + i, off, d);
			end
		end

		// ----- narrow writes
		bus_write(13, sha_accel_pkg::MEM_WIDTH_BYTE, 32'h1234_56a5);
		bus_read(13, 0, d);
		bus_write(14, sha_accel_pkg::MEM_WIDTH_HWORD, 32'hdead_beef);
		bus_read(14, 0, d);

		// ----- first vector
		load_vector(0);
		bus_write(0, sha_accel_pkg::MEM_WIDTH_WORD, 32'h1);
		wait_done(1'b0);
		read_schedule(0);

		// ----- same block, stalled run
		bus_write(0, sha_accel_pkg::MEM_WIDTH_WORD, 32'h1);
		wait_done(1'b1);
		read_schedule(0);

		// ----- second vector, rerun
		load_vector(1);
		bus_write(0, sha_accel_pkg::MEM_WIDTH_WORD, 32'h1);
		wait_done(1'b0);
		read_schedule(1);

		repeat (2) @(negedge clk);
		$display("errors: %0d check, %0d other, %0d checks done",
			u_checker.error_count, other_errors, u_checker.check_count);
		if (u_checker.error_count == 0 && other_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : tb_sha_accel

//--- test/sha_accel_patterns.hex
// two vectors of 18 words: block words 0 to 15 as written to the bus,
// then expected schedule words 16 and 63
// vector 0, "abc" padded, little-endian on the bus
80636261
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
18000000
61626380
12b1edeb
// vector 1, empty block
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000

//--- build.f
design/sha_accel_pkg.sv
design/dmem_port.sv
design/sched_ctrl.sv
design/msg_block_regs.sv
design/sched_expand.sv
design/sha_accel_top.sv
test/sha_accel_checker.sv
test/tb_sha_accel.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sha_accel -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_sha_accel)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
